//--- design/standby_pkg.sv
// Addresses are 7 bits and a descriptor counts at most 255 bytes; CCC, IBI and HDR are not modeled
package standby_pkg;

  typedef struct packed {
    logic       i2c_standby_en;
    logic       i3c_standby_en;
    logic [6:0] static_addr;
    logic [6:0] dynamic_addr;
  } core_config_t;

  typedef enum logic {
    MODE_I2C = 1'b0,
    MODE_I3C = 1'b1
  } bus_mode_e;

  typedef struct packed {
    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } bus_event_t;

  typedef struct packed {
    bus_mode_e  mode;
    logic [6:0] addr;
    logic       rnw;
    logic [7:0] byte_count;
    logic       error;
  } rx_desc_t;

  localparam int unsigned RxDescWidth = $bits(rx_desc_t);

  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    ADDR_ACK,
    WDATA,
    WACK,
    RDATA,
    RACK,
    IGNORE
  } tgt_state_e;

  // Returned to the master when no TX byte is queued
  localparam logic [7:0] IDLE_READ_BYTE = 8'hFF;

endpackage

//--- design/bus_sampler.sv
// Pins idle high and must be much slower than clk_i; every event lags its pin change by 3 cycles
module bus_sampler
  import standby_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       scl_i,
  input  logic       sda_i,
  output bus_event_t bus_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_prev_q;
  logic       sda_prev_q;
  logic       scl_s;
  logic       sda_s;

  assign scl_s = scl_sync_q[1];
  assign sda_s = sda_sync_q[1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      bus_o      <= '{start: 1'b0, stop: 1'b0, scl_rise: 1'b0, scl_fall: 1'b0, sda: 1'b1};
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;
      // SDA moving while SCL stays high marks START or STOP
      bus_o.start    <= scl_s & scl_prev_q & sda_prev_q & ~sda_s;
      bus_o.stop     <= scl_s & scl_prev_q & ~sda_prev_q & sda_s;
      bus_o.scl_rise <= scl_s & ~scl_prev_q;
      bus_o.scl_fall <= ~scl_s & scl_prev_q;
      bus_o.sda      <= sda_s;
    end
  end

endmodule

//--- design/tti_queue.sv
// Depth must be 2 or more; rdata_o falls through and is only meaningful while rvalid_o is high
module tti_queue #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 8
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             wvalid_i,
  input  logic [Width-1:0] wdata_i,
  output logic             wready_o,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int unsigned PtrW = $clog2(Depth);
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wptr_q;
  logic [PtrW-1:0]  rptr_q;
  logic [CntW-1:0]  count_q;
  logic             push;
  logic             pop;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o   = (count_q == CntW'(Depth));
  assign empty_o  = (count_q == '0);
  assign wready_o = ~full_o;
  assign rvalid_o = ~empty_o;
  assign rdata_o  = mem_q[rptr_q];
  assign push     = wvalid_i & wready_o;
  assign pop      = rvalid_o & rready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= next_ptr(wptr_q);
      end
      if (pop) begin
        rptr_q <= next_ptr(rptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

//--- design/standby_i2c_target.sv
// Static address only and no clock stretching; a full RX queue NACKs the byte, empty TX reads FF
module standby_i2c_target
  import standby_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  bus_event_t bus_i,
  input  logic [6:0] static_addr_i,
  output logic       sda_o,
  output logic       rx_desc_wvalid_o,
  output rx_desc_t   rx_desc_wdata_o,
  input  logic       rx_desc_wready_i,
  output logic       rx_data_wvalid_o,
  output logic [7:0] rx_data_wdata_o,
  input  logic       rx_data_wready_i,
  input  logic       tx_data_rvalid_i,
  input  logic [7:0] tx_data_rdata_i,
  output logic       tx_data_rready_o
);

  tgt_state_e state_q;
  logic [7:0] shift_q;
  logic [3:0] bit_cnt_q;
  logic [6:0] addr_q;
  logic       rnw_q;
  logic [7:0] byte_cnt_q;
  logic       err_q;
  logic       ack_q;
  logic       sda_q;
  logic       desc_pend_q;
  logic       desc_hold_q;
  rx_desc_t   desc_q;
  rx_desc_t   cur_desc;
  logic       desc_now;
  logic       desc_park;
  logic       load_tx;
  logic [7:0] tx_byte;

  assign cur_desc = '{mode: MODE_I2C, addr: addr_q, rnw: rnw_q,
                      byte_count: byte_cnt_q, error: err_q};

  // Descriptor goes out on the closing STOP or Sr, parked if the queue is busy
  assign desc_now         = desc_pend_q & (bus_i.start | bus_i.stop);
  assign desc_park        = desc_now & (desc_hold_q | ~rx_desc_wready_i);
  assign rx_desc_wvalid_o = desc_hold_q | desc_now;
  assign rx_desc_wdata_o  = desc_hold_q ? desc_q : cur_desc;

  assign rx_data_wvalid_o = (state_q == WACK) & bus_i.scl_rise & ack_q;
  assign rx_data_wdata_o  = shift_q;

  // Next read byte fetched on the falling edge that starts it
  assign load_tx          = bus_i.scl_fall & ((state_q == RACK) | ((state_q == ADDR_ACK) & rnw_q));
  assign tx_data_rready_o = load_tx;
  assign tx_byte          = tx_data_rvalid_i ? tx_data_rdata_i : IDLE_READ_BYTE;
  assign sda_o            = sda_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      desc_hold_q <= 1'b0;
    end else if (desc_park) begin
      desc_hold_q <= 1'b1;
    end else if (rx_desc_wready_i) begin
      desc_hold_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (desc_park) begin
      desc_q <= cur_desc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IDLE;
      bit_cnt_q   <= '0;
      rnw_q       <= 1'b0;
      byte_cnt_q  <= '0;
      err_q       <= 1'b0;
      ack_q       <= 1'b0;
      sda_q       <= 1'b1;
      desc_pend_q <= 1'b0;
    end else if (bus_i.start || bus_i.stop) begin
      state_q     <= bus_i.start ? ADDR : IDLE;
      bit_cnt_q   <= '0;
      sda_q       <= 1'b1;
      desc_pend_q <= 1'b0;
    end else begin
      unique case (state_q)
        ADDR, WDATA: begin
          if (bus_i.scl_rise) begin
            shift_q   <= {shift_q[6:0], bus_i.sda};
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end else if (bus_i.scl_fall && bit_cnt_q == 4'd8) begin
            bit_cnt_q <= '0;
            if (state_q == WDATA) begin
              // ACK only if the byte has room
              state_q <= WACK;
              ack_q   <= rx_data_wready_i;
              sda_q   <= ~rx_data_wready_i;
              err_q   <= err_q | ~rx_data_wready_i;
            end else if (shift_q[7:1] == static_addr_i) begin
              state_q     <= ADDR_ACK;
              sda_q       <= 1'b0;
              addr_q      <= shift_q[7:1];
              rnw_q       <= shift_q[0];
              byte_cnt_q  <= '0;
              err_q       <= 1'b0;
              desc_pend_q <= 1'b1;
            end else begin
              state_q <= IGNORE;
            end
          end
        end
        WACK: begin
          if (rx_data_wvalid_o && rx_data_wready_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end else if (rx_data_wvalid_o) begin
            err_q <= 1'b1;
          end
          if (bus_i.scl_fall) begin
            state_q <= WDATA;
            sda_q   <= 1'b1;
          end
        end
        ADDR_ACK, RACK: begin
          if (state_q == RACK && bus_i.scl_rise && bus_i.sda) begin
            state_q <= IGNORE;
          end else if (load_tx) begin
            state_q   <= RDATA;
            shift_q   <= tx_byte;
            sda_q     <= tx_byte[7];
            bit_cnt_q <= 4'd1;
          end else if (bus_i.scl_fall) begin
            state_q <= WDATA;
            sda_q   <= 1'b1;
          end
        end
        RDATA: begin
          if (bus_i.scl_fall && bit_cnt_q == 4'd8) begin
            state_q    <= RACK;
            sda_q      <= 1'b1;
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end else if (bus_i.scl_fall) begin
            shift_q   <= {shift_q[6:0], 1'b0};
            sda_q     <= shift_q[6];
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

//--- design/standby_i3c_target.sv
// SDR private writes to the dynamic address only; reads are NACKed and CCCs are not decoded
module standby_i3c_target
  import standby_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  bus_event_t bus_i,
  input  logic [6:0] dynamic_addr_i,
  output logic       sda_o,
  output logic       rx_desc_wvalid_o,
  output rx_desc_t   rx_desc_wdata_o,
  input  logic       rx_desc_wready_i,
  output logic       rx_data_wvalid_o,
  output logic [7:0] rx_data_wdata_o,
  input  logic       rx_data_wready_i
);

  tgt_state_e state_q;
  logic [7:0] shift_q;
  logic [3:0] bit_cnt_q;
  logic [6:0] addr_q;
  logic [7:0] byte_cnt_q;
  logic       err_q;
  logic       sda_q;
  logic       desc_pend_q;
  logic       desc_hold_q;
  rx_desc_t   desc_q;
  rx_desc_t   cur_desc;
  logic       desc_now;
  logic       desc_park;
  logic       parity_ok;

  assign cur_desc = '{mode: MODE_I3C, addr: addr_q, rnw: 1'b0,
                      byte_count: byte_cnt_q, error: err_q};

  assign desc_now         = desc_pend_q & (bus_i.start | bus_i.stop);
  assign desc_park        = desc_now & (desc_hold_q | ~rx_desc_wready_i);
  assign rx_desc_wvalid_o = desc_hold_q | desc_now;
  assign rx_desc_wdata_o  = desc_hold_q ? desc_q : cur_desc;

  // T-bit makes the ones count odd over byte plus T
  assign parity_ok        = ^{shift_q, bus_i.sda};
  assign rx_data_wvalid_o = (state_q == WACK) & bus_i.scl_rise & parity_ok;
  assign rx_data_wdata_o  = shift_q;
  assign sda_o            = sda_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      desc_hold_q <= 1'b0;
    end else if (desc_park) begin
      desc_hold_q <= 1'b1;
    end else if (rx_desc_wready_i) begin
      desc_hold_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (desc_park) begin
      desc_q <= cur_desc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IDLE;
      bit_cnt_q   <= '0;
      byte_cnt_q  <= '0;
      err_q       <= 1'b0;
      sda_q       <= 1'b1;
      desc_pend_q <= 1'b0;
    end else if (bus_i.start || bus_i.stop) begin
      state_q     <= bus_i.start ? ADDR : IDLE;
      bit_cnt_q   <= '0;
      sda_q       <= 1'b1;
      desc_pend_q <= 1'b0;
    end else begin
      unique case (state_q)
        ADDR, WDATA: begin
          if (bus_i.scl_rise) begin
            shift_q   <= {shift_q[6:0], bus_i.sda};
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end else if (bus_i.scl_fall && bit_cnt_q == 4'd8) begin
            bit_cnt_q <= '0;
            if (state_q == WDATA) begin
              state_q <= WACK;
            end else if (shift_q == {dynamic_addr_i, 1'b0}) begin
              state_q     <= ADDR_ACK;
              sda_q       <= 1'b0;
              addr_q      <= shift_q[7:1];
              byte_cnt_q  <= '0;
              err_q       <= 1'b0;
              desc_pend_q <= 1'b1;
            end else begin
              // Wrong address or a private read
              state_q <= IGNORE;
            end
          end
        end
        ADDR_ACK: begin
          if (bus_i.scl_fall) begin
            state_q <= WDATA;
            sda_q   <= 1'b1;
          end
        end
        WACK: begin
          if (bus_i.scl_rise && parity_ok && rx_data_wready_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end else if (bus_i.scl_rise) begin
            err_q <= 1'b1;
          end
          if (bus_i.scl_fall) begin
            state_q <= WDATA;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

//--- design/controller_standby.sv
// I2C wins when both enables are set, I3C when neither is; config must hold during a transaction
module controller_standby
  import standby_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  core_config_t core_config_i,
  input  logic         scl_i,
  input  logic         sda_i,
  output logic         sda_o,
  output logic         rx_desc_wvalid_o,
  output rx_desc_t     rx_desc_wdata_o,
  input  logic         rx_desc_wready_i,
  output logic         rx_data_wvalid_o,
  output logic [7:0]   rx_data_wdata_o,
  input  logic         rx_data_wready_i,
  input  logic         tx_data_rvalid_i,
  input  logic [7:0]   tx_data_rdata_i,
  output logic         tx_data_rready_o
);

  bus_mode_e  mode_sel;
  logic       sel_i2c;
  bus_event_t bus;
  logic       i2c_sda;
  logic       i3c_sda;
  logic       i2c_desc_wvalid;
  logic       i3c_desc_wvalid;
  rx_desc_t   i2c_desc_wdata;
  rx_desc_t   i3c_desc_wdata;
  logic       i2c_data_wvalid;
  logic       i3c_data_wvalid;
  logic [7:0] i2c_data_wdata;
  logic [7:0] i3c_data_wdata;
  logic       i2c_tx_rready;

  // I3C is the fallback whether or not its enable is set
  always_comb begin
    if (core_config_i.i2c_standby_en) begin
      mode_sel = MODE_I2C;
    end else begin
      mode_sel = MODE_I3C;
    end
  end

  assign sel_i2c = (mode_sel == MODE_I2C);

  always_comb begin
    sda_o            = sel_i2c ? i2c_sda : i3c_sda;
    rx_desc_wvalid_o = sel_i2c ? i2c_desc_wvalid : i3c_desc_wvalid;
    rx_desc_wdata_o  = sel_i2c ? i2c_desc_wdata : i3c_desc_wdata;
    rx_data_wvalid_o = sel_i2c ? i2c_data_wvalid : i3c_data_wvalid;
    rx_data_wdata_o  = sel_i2c ? i2c_data_wdata : i3c_data_wdata;
    tx_data_rready_o = sel_i2c & i2c_tx_rready;
  end

  bus_sampler xbus_sampler (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .scl_i (scl_i),
    .sda_i (sda_i),
    .bus_o (bus)
  );

  // Idle engine sees no queue room and no TX data
  standby_i2c_target xstandby_i2c_target (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .bus_i            (bus),
    .static_addr_i    (core_config_i.static_addr),
    .sda_o            (i2c_sda),
    .rx_desc_wvalid_o (i2c_desc_wvalid),
    .rx_desc_wdata_o  (i2c_desc_wdata),
    .rx_desc_wready_i (rx_desc_wready_i & sel_i2c),
    .rx_data_wvalid_o (i2c_data_wvalid),
    .rx_data_wdata_o  (i2c_data_wdata),
    .rx_data_wready_i (rx_data_wready_i & sel_i2c),
    .tx_data_rvalid_i (tx_data_rvalid_i & sel_i2c),
    .tx_data_rdata_i  (tx_data_rdata_i),
    .tx_data_rready_o (i2c_tx_rready)
  );

  standby_i3c_target xstandby_i3c_target (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .bus_i            (bus),
    .dynamic_addr_i   (core_config_i.dynamic_addr),
    .sda_o            (i3c_sda),
    .rx_desc_wvalid_o (i3c_desc_wvalid),
    .rx_desc_wdata_o  (i3c_desc_wdata),
    .rx_desc_wready_i (rx_desc_wready_i & ~sel_i2c),
    .rx_data_wvalid_o (i3c_data_wvalid),
    .rx_data_wdata_o  (i3c_data_wdata),
    .rx_data_wready_i (rx_data_wready_i & ~sel_i2c)
  );

endmodule

//--- design/standby_top.sv
// No fixed latency; a transaction has ended once rx_desc_rvalid_o rises, depths must be 2 or more
module standby_top
  import standby_pkg::*;
#(
  parameter int unsigned RxDescDepth = 4,
  parameter int unsigned RxDataDepth = 8,
  parameter int unsigned TxDataDepth = 8
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  core_config_t core_config_i,
  input  logic         scl_i,
  input  logic         sda_i,
  output logic         sda_o,
  output logic         rx_desc_rvalid_o,
  input  logic         rx_desc_rready_i,
  output rx_desc_t     rx_desc_o,
  output logic         rx_data_rvalid_o,
  input  logic         rx_data_rready_i,
  output logic [7:0]   rx_data_o,
  input  logic         tx_data_wvalid_i,
  output logic         tx_data_wready_o,
  input  logic [7:0]   tx_data_i
);

  logic       rx_desc_wvalid;
  rx_desc_t   rx_desc_wdata;
  logic       rx_desc_wready;
  logic       rx_data_wvalid;
  logic [7:0] rx_data_wdata;
  logic       rx_data_wready;
  logic       tx_data_rvalid;
  logic [7:0] tx_data_rdata;
  logic       tx_data_rready;

  controller_standby xcontroller_standby (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .core_config_i    (core_config_i),
    .scl_i            (scl_i),
    .sda_i            (sda_i),
    .sda_o            (sda_o),
    .rx_desc_wvalid_o (rx_desc_wvalid),
    .rx_desc_wdata_o  (rx_desc_wdata),
    .rx_desc_wready_i (rx_desc_wready),
    .rx_data_wvalid_o (rx_data_wvalid),
    .rx_data_wdata_o  (rx_data_wdata),
    .rx_data_wready_i (rx_data_wready),
    .tx_data_rvalid_i (tx_data_rvalid),
    .tx_data_rdata_i  (tx_data_rdata),
    .tx_data_rready_o (tx_data_rready)
  );

  tti_queue #(.Width(RxDescWidth), .Depth(RxDescDepth)) xrx_desc_queue (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wvalid_i (rx_desc_wvalid),
    .wdata_i  (rx_desc_wdata),
    .wready_o (rx_desc_wready),
    .rvalid_o (rx_desc_rvalid_o),
    .rready_i (rx_desc_rready_i),
    .rdata_o  (rx_desc_o),
    .full_o   (),
    .empty_o  ()
  );

  tti_queue #(.Width(8), .Depth(RxDataDepth)) xrx_data_queue (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wvalid_i (rx_data_wvalid),
    .wdata_i  (rx_data_wdata),
    .wready_o (rx_data_wready),
    .rvalid_o (rx_data_rvalid_o),
    .rready_i (rx_data_rready_i),
    .rdata_o  (rx_data_o),
    .full_o   (),
    .empty_o  ()
  );

  tti_queue #(.Width(8), .Depth(TxDataDepth)) xtx_data_queue (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wvalid_i (tx_data_wvalid_i),
    .wdata_i  (tx_data_i),
    .wready_o (tx_data_wready_o),
    .rvalid_o (tx_data_rvalid),
    .rready_i (tx_data_rready),
    .rdata_o  (tx_data_rdata),
    .full_o   (),
    .empty_o  ()
  );

endmodule

//--- verification/standby_tb.sv
// Directed tests only; each SCL phase lasts 10 clock cycles and addresses must stay distinct
module standby_tb
  import standby_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TimeoutCycles = 30000;
  localparam int unsigned PhaseCycles   = 10;
  localparam logic [6:0]  StaticAddr    = 7'h2A;
  localparam logic [6:0]  DynamicAddr   = 7'h31;
  localparam logic [6:0]  WrongAddr     = 7'h55;

  typedef logic [7:0] byte_q_t[$];

  logic         clk;
  logic         rst;
  core_config_t cfg;
  logic         scl;
  logic         sda_m;
  logic         sda_line;
  logic         dut_sda;
  logic         rx_desc_rvalid;
  logic         rx_desc_rready;
  rx_desc_t     rx_desc;
  logic         rx_data_rvalid;
  logic         rx_data_rready;
  logic [7:0]   rx_data;
  logic         tx_data_wvalid;
  logic         tx_data_wready;
  logic [7:0]   tx_data;
  int unsigned  cycle_cnt = 0;
  int unsigned  error_cnt;
  int unsigned  test_cnt;
  logic [31:0]  lcg_state;

  // Open-drain line, either side pulls it low
  assign sda_line = sda_m & dut_sda;

  standby_top #(.RxDataDepth(4)) uut (
    .clk_i            (clk),
    .rst_i            (rst),
    .core_config_i    (cfg),
    .scl_i            (scl),
    .sda_i            (sda_line),
    .sda_o            (dut_sda),
    .rx_desc_rvalid_o (rx_desc_rvalid),
    .rx_desc_rready_i (rx_desc_rready),
    .rx_desc_o        (rx_desc),
    .rx_data_rvalid_o (rx_data_rvalid),
    .rx_data_rready_i (rx_data_rready),
    .rx_data_o        (rx_data),
    .tx_data_wvalid_i (tx_data_wvalid),
    .tx_data_wready_o (tx_data_wready),
    .tx_data_i        (tx_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt == TimeoutCycles);
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("Regression failed");
    $finish;
  end

  function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
  endfunction

  task automatic wait_clks(input int unsigned n);
    repeat (n) @(posedge clk);
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] %s: %s expected %0h, actual %0h", test, what, exp, act);
    error_cnt++;
  endtask

  task automatic report_failure(input string test, input string what);
    $display("%s: %s", test, what);
    error_cnt++;
  endtask

  task automatic apply_reset();
    rst <= 1'b1;
    wait_clks(4);
    rst <= 1'b0;
    wait_clks(1);
  endtask

  task automatic set_mode(input logic i2c_en, input logic i3c_en);
    cfg <= '{i2c_standby_en: i2c_en, i3c_standby_en: i3c_en,
             static_addr: StaticAddr, dynamic_addr: DynamicAddr};
    wait_clks(2);
  endtask

  task automatic bus_start();
    scl <= 1'b0;
    wait_clks(4);
    sda_m <= 1'b1;
    wait_clks(PhaseCycles - 4);
    scl <= 1'b1;
    wait_clks(PhaseCycles);
    sda_m <= 1'b0;
    wait_clks(PhaseCycles);
  endtask

  task automatic bus_stop();
    scl <= 1'b0;
    wait_clks(4);
    sda_m <= 1'b0;
    wait_clks(PhaseCycles - 4);
    scl <= 1'b1;
    wait_clks(PhaseCycles);
    sda_m <= 1'b1;
    wait_clks(PhaseCycles);
  endtask

  // SDA only moves while SCL is low
  task automatic bus_write_bit(input logic b);
    scl <= 1'b0;
    wait_clks(4);
    sda_m <= b;
    wait_clks(PhaseCycles - 4);
    scl <= 1'b1;
    wait_clks(PhaseCycles);
  endtask

  task automatic bus_read_bit(output logic b);
    scl <= 1'b0;
    wait_clks(4);
    sda_m <= 1'b1;
    wait_clks(PhaseCycles - 4);
    scl <= 1'b1;
    wait_clks(PhaseCycles / 2);
    b = sda_line;
    wait_clks(PhaseCycles / 2);
  endtask

  task automatic bus_write_byte(input logic [7:0] b, output logic ack);
    logic bit_v;
    for (int i = 7; i >= 0; i--) begin
      bus_write_bit(b[i]);
    end
    bus_read_bit(bit_v);
    ack = ~bit_v;
  endtask

  task automatic bus_read_byte(input logic ack, output logic [7:0] b);
    logic bit_v;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      bus_read_bit(bit_v);
      b = {b[6:0], bit_v};
    end
    bus_write_bit(~ack);
  endtask

  // acks bit 0 is the address, bit n+1 is data byte n
  task automatic write_txn(input logic [7:0] addr_byte, input byte_q_t data,
                           output logic [15:0] acks);
    logic ack;
    acks = '0;
    bus_start();
    bus_write_byte(addr_byte, ack);
    acks[0] = ack;
    foreach (data[i]) begin
      bus_write_byte(data[i], ack);
      acks[i + 1] = ack;
    end
    bus_stop();
  endtask

  task automatic push_tx(input logic [7:0] b);
    tx_data <= b;
    tx_data_wvalid <= 1'b1;
    wait_clks(1);
    if (!tx_data_wready) report_failure("push_tx", "TX queue refused a byte");
    tx_data_wvalid <= 1'b0;
  endtask

  task automatic pop_desc(input string test, output rx_desc_t d);
    int unsigned waited;
    waited = 0;
    d = '0;
    while (!rx_desc_rvalid && waited < 100) begin
      wait_clks(1);
      waited++;
    end
    if (!rx_desc_rvalid) begin
      report_failure(test, "no descriptor arrived after the STOP");
    end else begin
      d = rx_desc;
      rx_desc_rready <= 1'b1;
      wait_clks(1);
      rx_desc_rready <= 1'b0;
      wait_clks(1);
    end
  endtask

  task automatic pop_data(input string test, output logic [7:0] b);
    int unsigned waited;
    waited = 0;
    b = 'x;
    while (!rx_data_rvalid && waited < 100) begin
      wait_clks(1);
      waited++;
    end
    if (!rx_data_rvalid) begin
      report_failure(test, "an expected byte is missing from the RX data queue");
    end else begin
      b = rx_data;
      rx_data_rready <= 1'b1;
      wait_clks(1);
      rx_data_rready <= 1'b0;
      wait_clks(1);
    end
  endtask

  task automatic check_desc(input string test, input rx_desc_t exp);
    rx_desc_t d;
    pop_desc(test, d);
    if (d !== exp) report_mismatch(test, "descriptor", 32'(exp), 32'(d));
  endtask

  task automatic check_data(input string test, input byte_q_t exp);
    logic [7:0] b;
    foreach (exp[i]) begin
      pop_data(test, b);
      if (b !== exp[i]) report_mismatch(test, "RX data byte", 32'(exp[i]), 32'(b));
    end
    if (rx_data_rvalid) report_failure(test, "RX data queue holds extra bytes");
  endtask

  task automatic expect_quiet(input string test);
    wait_clks(20);
    if (rx_desc_rvalid) report_failure(test, "a descriptor appeared for a foreign address");
    if (rx_data_rvalid) report_failure(test, "data appeared for a foreign address");
  endtask

  task automatic write_to_static_addr();
    byte_q_t     data;
    logic [15:0] acks;
    test_cnt++;
    set_mode(1'b1, 1'b0);
    data = {rand_byte(), rand_byte(), rand_byte()};
    write_txn({StaticAddr, 1'b0}, data, acks);
    if (acks !== 16'h000F) report_mismatch("i2c_write", "ACK pattern", 32'h000F, 32'(acks));
    check_desc("i2c_write", '{mode: MODE_I2C, addr: StaticAddr, rnw: 1'b0,
                              byte_count: 8'd3, error: 1'b0});
    check_data("i2c_write", data);
  endtask

  // A data byte follows the NACKed address so that a wrongly kept byte would show
  task automatic reject_wrong_addr();
    byte_q_t     data;
    logic [15:0] acks;
    test_cnt++;
    set_mode(1'b1, 1'b0);
    data = {rand_byte()};
    write_txn({WrongAddr, 1'b0}, data, acks);
    if (acks !== 16'h0000) report_mismatch("addr_mismatch_i2c", "ACK pattern", 0, 32'(acks));
    expect_quiet("addr_mismatch_i2c");
    // Private reads are not supported in I3C mode
    set_mode(1'b0, 1'b1);
    data = {rand_byte()};
    write_txn({DynamicAddr, 1'b1}, data, acks);
    if (acks !== 16'h0000) report_mismatch("addr_mismatch_i3c", "ACK pattern", 0, 32'(acks));
    expect_quiet("addr_mismatch_i3c");
  endtask

  task automatic read_from_static_addr();
    logic [7:0] tx0;
    logic [7:0] tx1;
    logic [7:0] b;
    logic       ack;
    test_cnt++;
    set_mode(1'b1, 1'b0);
    tx0 = rand_byte();
    tx1 = rand_byte();
    push_tx(tx0);
    push_tx(tx1);
    bus_start();
    bus_write_byte({StaticAddr, 1'b1}, ack);
    if (ack !== 1'b1) report_mismatch("i2c_read", "address ACK", 1, 32'(ack));
    bus_read_byte(1'b1, b);
    if (b !== tx0) report_mismatch("i2c_read", "read byte 0", 32'(tx0), 32'(b));
    bus_read_byte(1'b1, b);
    if (b !== tx1) report_mismatch("i2c_read", "read byte 1", 32'(tx1), 32'(b));
    // TX queue is empty by now
    bus_read_byte(1'b0, b);
    if (b !== 8'hFF) report_mismatch("i2c_read", "read byte 2", 32'hFF, 32'(b));
    bus_stop();
    check_desc("i2c_read", '{mode: MODE_I2C, addr: StaticAddr, rnw: 1'b1,
                             byte_count: 8'd3, error: 1'b0});
    if (rx_data_rvalid) report_failure("i2c_read", "a read left bytes in the RX data queue");
  endtask

  task automatic write_with_parity();
    byte_q_t    good;
    logic [7:0] b;
    logic       ack;
    logic       t;
    test_cnt++;
    set_mode(1'b0, 1'b1);
    bus_start();
    bus_write_byte({DynamicAddr, 1'b0}, ack);
    if (ack !== 1'b1) report_mismatch("i3c_parity", "address ACK", 1, 32'(ack));
    for (int n = 0; n < 4; n++) begin
      b = rand_byte();
      for (int i = 7; i >= 0; i--) begin
        bus_write_bit(b[i]);
      end
      t = ~(^b) ^ (n == 2);  // third byte gets a wrong T-bit
      bus_write_bit(t);
      if (n != 2) good.push_back(b);
    end
    bus_stop();
    check_desc("i3c_parity", '{mode: MODE_I3C, addr: DynamicAddr, rnw: 1'b0,
                               byte_count: 8'd3, error: 1'b1});
    check_data("i3c_parity", good);
  endtask

  task automatic overflow_rx_data();
    byte_q_t     data;
    byte_q_t     kept;
    logic [15:0] acks;
    logic [7:0]  b;
    test_cnt++;
    set_mode(1'b1, 1'b0);
    for (int n = 0; n < 6; n++) begin
      b = rand_byte();
      data.push_back(b);
      if (n < 4) kept.push_back(b);
    end
    write_txn({StaticAddr, 1'b0}, data, acks);
    // Address and four bytes fit in the queue
    if (acks !== 16'h001F) report_mismatch("overflow", "ACK pattern", 32'h001F, 32'(acks));
    check_desc("overflow", '{mode: MODE_I2C, addr: StaticAddr, rnw: 1'b0,
                             byte_count: 8'd4, error: 1'b1});
    check_data("overflow", kept);
  endtask

  // Reset hits with queued bytes and the DUT pulling SDA low for an address ACK
  task automatic select_mode_after_reset();
    byte_q_t     data;
    logic [15:0] acks;
    logic [7:0]  addr_byte;
    test_cnt++;
    addr_byte = {StaticAddr, 1'b0};
    set_mode(1'b1, 1'b0);
    data = {rand_byte()};
    write_txn(addr_byte, data, acks);
    bus_start();
    for (int i = 7; i >= 0; i--) begin
      bus_write_bit(addr_byte[i]);
    end
    scl <= 1'b0;
    wait_clks(PhaseCycles);
    apply_reset();
    if (dut_sda !== 1'b1) report_mismatch("mode_reset", "sda_o after reset", 1, 32'(dut_sda));
    if (rx_desc_rvalid !== 1'b0) report_failure("mode_reset", "descriptor valid after reset");
    if (rx_data_rvalid !== 1'b0) report_failure("mode_reset", "data valid after reset");
    bus_stop();
    set_mode(1'b1, 1'b1);
    data = {rand_byte(), rand_byte()};
    write_txn(addr_byte, data, acks);
    if (acks !== 16'h0007) report_mismatch("mode_reset", "ACK pattern", 32'h0007, 32'(acks));
    check_desc("mode_reset", '{mode: MODE_I2C, addr: StaticAddr, rnw: 1'b0,
                               byte_count: 8'd2, error: 1'b0});
    check_data("mode_reset", data);
  endtask

  initial begin
    lcg_state      = 32'h799b;
    error_cnt      = 0;
    test_cnt       = 0;
    rst            = 1'b1;
    cfg            = '{i2c_standby_en: 1'b1, i3c_standby_en: 1'b0,
                       static_addr: StaticAddr, dynamic_addr: DynamicAddr};
    scl            = 1'b1;
    sda_m          = 1'b1;
    rx_desc_rready = 1'b0;
    rx_data_rready = 1'b0;
    tx_data_wvalid = 1'b0;
    tx_data        = 8'h00;
    apply_reset();
    write_to_static_addr();
    reject_wrong_addr();
    read_from_static_addr();
    write_with_parity();
    overflow_rx_data();
    select_mode_after_reset();
    $display("Tests run: %0d, errors: %0d", test_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- standby_top.f
design/standby_pkg.sv
design/bus_sampler.sv
design/tti_queue.sv
design/standby_i2c_target.sv
design/standby_i3c_target.sv
design/controller_standby.sv
design/standby_top.sv
verification/standby_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := standby_tb
FILELIST := standby_top.f
BUILD    := obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf $(BUILD)
